/* list.f */
+incdir+.
CoreTypes.sv
RegFile.sv
PcFile.sv
OperandLoad.sv
IntAlu.sv
ExecCluster.sv
ExecCluster_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the execute cluster testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ExecCluster_tb -f list.f -o simv

# The simulator exits nonzero on a fatal check, so keep its output either way
output="$(./obj_dir/simv 2>&1 || true)"
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
fi
exit 1

/* ExecCluster_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ExecCluster_tb import CoreTypes::*; ();

    logic clk;
    logic rst;
    logic uopValid[`NUM_PORTS];
    Tag uopTagA[`NUM_PORTS];
    Tag uopTagB[`NUM_PORTS];
    Tag uopTagDst[`NUM_PORTS];
    SqN uopSqN[`NUM_PORTS];
    AluOp uopOp[`NUM_PORTS];
    Word uopImm[`NUM_PORTS];
    logic uopImmB[`NUM_PORTS];
    FetchId uopFetchId[`NUM_PORTS];
    FetchOffs uopFetchOffs[`NUM_PORTS];
    logic uopCompressed[`NUM_PORTS];
    logic invalidate;
    SqN invalidateSqN;
    logic pcWriteEn;
    FetchId pcWriteId;
    Word pcWriteBase;
    logic stall[`NUM_PORTS];
    logic wbValid[`NUM_PORTS];
    Tag wbTagDst[`NUM_PORTS];
    SqN wbSqN[`NUM_PORTS];
    Word wbResult[`NUM_PORTS];

    // Reference model state
    Word regs[`NUM_PREGS];
    logic ready[`NUM_PREGS];
    Word bases[`NUM_FETCH];
    logic live[128];
    Tag liveDst[128];
    Word liveRes[128];
    SqN nextSqN;
    Tag fwdTag;
    logic fwdOk;
    logic [31:0] seed;
    int liveCount;
    int fwdUsed;
    int killCount;
    int stallCycles;
    int stallRun[`NUM_PORTS];

    ExecCluster dut (.*);

    always #10 clk = ~clk;

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input Word got, input Word exp);
        if (got !== exp) failNow($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic checkTag(input string name, input Tag got, input Tag exp);
        if (got !== exp) failNow($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) failNow($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    function automatic Word nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Newer means ahead by less than half the sequence space
    function automatic logic isNewer(input SqN a, input SqN b);
        SqN d;
        d = a - b;
        return d != 7'd0 && d < 7'd64;
    endfunction

    function automatic Word operandValue(input Tag t);
        if (t[6]) return {{26{t[5]}}, t[5:0]};
        return regs[t[5:0]];
    endfunction

    function automatic Word aluModel(input AluOp op, input Word a, input Word b,
                                     input Word pc, input logic comp);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSll:   return a << b[4:0];
            opSrl:   return a >> b[4:0];
            opLink:  return pc + (comp ? 32'd2 : 32'd4);
            default: return 32'd0;
        endcase
    endfunction

    function automatic Tag pickReady(input logic [5:0] start);
        Tag t;
        logic [5:0] idx;
        logic found;
        t = {1'b1, 6'd0};
        found = 1'b0;
        for (int k = 0; k < `NUM_PREGS; k++) begin
            idx = start + k[5:0];
            if (!found && ready[idx]) begin
                t = {1'b0, idx};
                found = 1'b1;
            end
        end
        return t;
    endfunction

    // Bias toward a tag on the writeback bus this cycle
    function automatic Tag pickSource();
        Word r;
        r = nextRand();
        if (r[1:0] == 2'd0) return {1'b1, r[10:5]};
        if (fwdOk && r[2] && ready[fwdTag[5:0]]) return fwdTag;
        return pickReady(r[21:16]);
    endfunction

    task automatic idleInputs();
        for (int p = 0; p < `NUM_PORTS; p++) begin
            uopValid[p] = 1'b0;
        end
        invalidate = 1'b0;
        pcWriteEn = 1'b0;
    endtask

    task automatic launch(input int p, input AluOp op, input Tag ta, input Tag tb, input Tag td,
                          input Word imm, input logic immB, input FetchId fid,
                          input FetchOffs offs, input logic comp);
        Word a;
        Word b;
        Word pc;
        a = operandValue(ta);
        b = immB ? imm : operandValue(tb);
        // Offset marks the end of the instruction
        pc = bases[fid] + {28'd0, offs, 1'b0} - (comp ? 32'd0 : 32'd2);
        uopValid[p] = 1'b1;
        uopTagA[p] = ta;
        uopTagB[p] = tb;
        uopTagDst[p] = td;
        uopSqN[p] = nextSqN;
        uopOp[p] = op;
        uopImm[p] = imm;
        uopImmB[p] = immB;
        uopFetchId[p] = fid;
        uopFetchOffs[p] = offs;
        uopCompressed[p] = comp;
        if (fwdOk && (ta == fwdTag || (!immB && tb == fwdTag))) fwdUsed++;
        live[nextSqN] = 1'b1;
        liveDst[nextSqN] = td;
        liveRes[nextSqN] = aluModel(op, a, b, pc, comp);
        ready[td[5:0]] = 1'b0;
        liveCount++;
        nextSqN = nextSqN + 7'd1;
    endtask

    task automatic issuePort(input int p);
        Word r1;
        Word r2;
        Word r3;
        Tag ta;
        Tag tb;
        Tag td;
        r1 = nextRand();
        r2 = nextRand();
        r3 = nextRand();
        ta = pickSource();
        tb = pickSource();
        td = pickReady(r1[21:16]);
        launch(p, AluOp'(4'(r1 % 9)), ta, tb, td, r2, r1[8:7] == 2'd0,
               r3[2:0], r3[5:3], r3[6]);
    endtask

    task automatic collectResults();
        SqN s;
        fwdOk = 1'b0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (wbValid[p]) begin
                s = wbSqN[p];
                if (!live[s]) begin
                    failNow($sformatf("port %0d completed sequence number %h that is not in flight",
                                      p, s));
                end else begin
                    checkTag("wbTagDst", wbTagDst[p], liveDst[s]);
                    checkWord("wbResult", wbResult[p], liveRes[s]);
                    live[s] = 1'b0;
                    liveCount--;
                    regs[liveDst[s][5:0]] = liveRes[s];
                    ready[liveDst[s][5:0]] = 1'b1;
                    fwdTag = liveDst[s];
                    fwdOk = 1'b1;
                end
            end
        end
    endtask

    // Killed micro-ops never wrote, so their tags keep the old values
    task automatic flushYounger();
        Word r;
        SqN inv;
        r = nextRand();
        inv = nextSqN - 7'd1 - {5'd0, r[1:0]};
        invalidate = 1'b1;
        invalidateSqN = inv;
        for (int s = 0; s < 128; s++) begin
            if (live[s] && isNewer(s[6:0], inv)) begin
                live[s] = 1'b0;
                ready[liveDst[s][5:0]] = 1'b1;
                liveCount--;
                killCount++;
            end
        end
    endtask

    task automatic drainAll();
        int waitCycles;
        waitCycles = 0;
        while (liveCount != 0 && waitCycles < 200) begin
            @(negedge clk);
            collectResults();
            idleInputs();
            waitCycles++;
        end
        if (liveCount != 0) failNow("in-flight micro-ops did not complete before the timeout");
    endtask

    initial begin
        Word r;
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'h7fd1;
        nextSqN = '0;
        fwdOk = 1'b0;
        fwdTag = '0;
        liveCount = 0;
        fwdUsed = 0;
        killCount = 0;
        stallCycles = 0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            uopTagA[p] = '0;
            uopTagB[p] = '0;
            uopTagDst[p] = '0;
            uopSqN[p] = '0;
            uopOp[p] = opAdd;
            uopImm[p] = '0;
            uopImmB[p] = 1'b0;
            uopFetchId[p] = '0;
            uopFetchOffs[p] = '0;
            uopCompressed[p] = 1'b0;
            stallRun[p] = 0;
        end
        idleInputs();
        invalidateSqN = '0;
        pcWriteId = '0;
        pcWriteBase = '0;
        for (int t = 0; t < `NUM_PREGS; t++) begin
            regs[t] = '0;
            ready[t] = 1'b1;
        end
        for (int s = 0; s < 128; s++) begin
            live[s] = 1'b0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Load aligned block bases, nothing may come out meanwhile
        for (int f = 0; f <= `NUM_FETCH; f++) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                checkBit("wbValid", wbValid[p], 1'b0);
                checkBit("stall", stall[p], 1'b0);
            end
            pcWriteEn = 1'b0;
            if (f < `NUM_FETCH) begin
                r = nextRand();
                bases[f] = {r[31:4], 4'd0};
                pcWriteEn = 1'b1;
                pcWriteId = f[2:0];
                pcWriteBase = bases[f];
            end
            @(negedge clk);
        end
        idleInputs();

        for (int cyc = 0; cyc < 800; cyc++) begin
            @(negedge clk);
            collectResults();
            idleInputs();
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (stall[p]) begin
                    stallCycles++;
                    stallRun[p]++;
                    if (stallRun[p] > 40) failNow("an issue port stayed stalled too long");
                end else begin
                    stallRun[p] = 0;
                    if (nextRand() % 4 != 0) issuePort(p);
                end
            end
            if (nextRand() % 40 == 0) flushYounger();
        end
        drainAll();

        // Read back every register through the ALU
        for (int t = 0; t < `NUM_PREGS; t++) begin
            @(negedge clk);
            collectResults();
            idleInputs();
            launch(0, opOr, {1'b0, t[5:0]}, {1'b1, 6'd0}, {1'b0, t[5:0]}, 32'd0, 1'b1,
                   3'd0, 3'd0, 1'b0);
        end
        drainAll();

        if (fwdUsed == 0 || killCount == 0 || stallCycles == 0) begin
            failNow("random run did not reach the forwarding, invalidation and stall cases");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* ExecCluster.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ExecCluster import CoreTypes::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire logic     uopValid[`NUM_PORTS],
    input  wire Tag       uopTagA[`NUM_PORTS],
    input  wire Tag       uopTagB[`NUM_PORTS],
    input  wire Tag       uopTagDst[`NUM_PORTS],
    input  wire SqN       uopSqN[`NUM_PORTS],
    input  wire AluOp     uopOp[`NUM_PORTS],
    input  wire Word      uopImm[`NUM_PORTS],
    input  wire logic     uopImmB[`NUM_PORTS],
    input  wire FetchId   uopFetchId[`NUM_PORTS],
    input  wire FetchOffs uopFetchOffs[`NUM_PORTS],
    input  wire logic     uopCompressed[`NUM_PORTS],
    input  wire           invalidate,
    input  wire SqN       invalidateSqN,
    input  wire           pcWriteEn,
    input  wire FetchId   pcWriteId,
    input  wire Word      pcWriteBase,
    output logic          stall[`NUM_PORTS],
    output logic          wbValid[`NUM_PORTS],
    output Tag            wbTagDst[`NUM_PORTS],
    output SqN            wbSqN[`NUM_PORTS],
    output Word           wbResult[`NUM_PORTS]
);

    Tag rfReadAddr[2*`NUM_PORTS];
    Word rfReadData[2*`NUM_PORTS];
    FetchId pcReadAddr[`NUM_PORTS];
    Word pcReadData[`NUM_PORTS];

    logic exValid[`NUM_PORTS];
    Word exSrcA[`NUM_PORTS];
    Word exSrcB[`NUM_PORTS];
    Word exPc[`NUM_PORTS];
    AluOp exOp[`NUM_PORTS];
    Tag exTagDst[`NUM_PORTS];
    SqN exSqN[`NUM_PORTS];
    logic exCompressed[`NUM_PORTS];

    RegFile regFile (
        .clk, .rst, .readAddr(rfReadAddr), .readData(rfReadData),
        .writeEn(wbValid), .writeTag(wbTagDst), .writeData(wbResult)
    );

    PcFile pcFile (
        .clk, .rst, .writeEn(pcWriteEn), .writeId(pcWriteId), .writeBase(pcWriteBase),
        .readId(pcReadAddr), .readBase(pcReadData)
    );

    OperandLoad operandLoad (
        .clk, .rst, .uopValid, .uopTagA, .uopTagB, .uopTagDst, .uopSqN, .uopOp,
        .uopImm, .uopImmB, .uopFetchId, .uopFetchOffs, .uopCompressed,
        .invalidate, .invalidateSqN, .stall, .wbValid, .wbTagDst, .wbResult,
        .rfReadAddr, .pcReadAddr, .rfReadData, .pcReadData,
        .exValid, .exSrcA, .exSrcB, .exPc, .exOp, .exTagDst, .exSqN, .exCompressed
    );

    // ALU busy is the stall of its issue port
    for (genvar p = 0; p < `NUM_PORTS; p++) begin : gAlu
        IntAlu alu (
            .clk, .rst, .exValid(exValid[p]), .exSrcA(exSrcA[p]), .exSrcB(exSrcB[p]),
            .exPc(exPc[p]), .exOp(exOp[p]), .exTagDst(exTagDst[p]), .exSqN(exSqN[p]),
            .exCompressed(exCompressed[p]), .invalidate, .invalidateSqN,
            .busy(stall[p]), .wbValid(wbValid[p]), .wbTagDst(wbTagDst[p]),
            .wbSqN(wbSqN[p]), .wbResult(wbResult[p])
        );
    end

endmodule

`default_nettype wire

/* IntAlu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module IntAlu import CoreTypes::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire logic exValid,
    input  wire Word  exSrcA,
    input  wire Word  exSrcB,
    input  wire Word  exPc,
    input  wire AluOp exOp,
    input  wire Tag   exTagDst,
    input  wire SqN   exSqN,
    input  wire logic exCompressed,
    input  wire       invalidate,
    input  wire SqN   invalidateSqN,
    output logic      busy,
    output logic      wbValid,
    output Tag        wbTagDst,
    output SqN        wbSqN,
    output Word       wbResult
);

    AluState state;
    logic [4:0] shiftCnt;
    logic shiftLeft;
    logic accept;
    logic isShift;
    Word simpleResult;

    assign busy = (state == aluShift);
    assign accept = exValid && !busy && !(invalidate && isYounger(exSqN, invalidateSqN));
    assign isShift = (exOp == opSll || exOp == opSrl) && exSrcB[4:0] != 5'd0;

    always_comb begin
        case (exOp)
            opAdd:   simpleResult = exSrcA + exSrcB;
            opSub:   simpleResult = exSrcA - exSrcB;
            opAnd:   simpleResult = exSrcA & exSrcB;
            opOr:    simpleResult = exSrcA | exSrcB;
            opXor:   simpleResult = exSrcA ^ exSrcB;
            opSlt:   simpleResult = Word'($signed(exSrcA) < $signed(exSrcB));
            opLink:  simpleResult = exPc + (exCompressed ? 32'd2 : 32'd4);
            // Shift start value, also the result of a shift by zero
            default: simpleResult = exSrcA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= aluIdle;
            shiftCnt <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= 1'b0;
            case (state)
                aluIdle: begin
                    if (accept && isShift) begin
                        state <= aluShift;
                        shiftCnt <= exSrcB[4:0];
                    end else if (accept) begin
                        wbValid <= 1'b1;
                    end
                end
                aluShift: begin
                    if (invalidate && isYounger(wbSqN, invalidateSqN)) begin
                        state <= aluIdle;
                    end else begin
                        shiftCnt <= shiftCnt - 5'd1;
                        if (shiftCnt == 5'd1) begin
                            state <= aluIdle;
                            wbValid <= 1'b1;
                        end
                    end
                end
                default: state <= aluIdle;
            endcase
        end
    end

    // Result register doubles as the shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            wbTagDst <= exTagDst;
            wbSqN <= exSqN;
            shiftLeft <= (exOp == opSll);
            wbResult <= simpleResult;
        end else if (busy) begin
            wbResult <= shiftLeft ? wbResult << 1 : wbResult >> 1;
        end
    end

endmodule

`default_nettype wire

/* OperandLoad.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module OperandLoad import CoreTypes::*; (
    input  wire           clk,
    input  wire           rst,

    // Issue
    input  wire logic     uopValid[`NUM_PORTS],
    input  wire Tag       uopTagA[`NUM_PORTS],
    input  wire Tag       uopTagB[`NUM_PORTS],
    input  wire Tag       uopTagDst[`NUM_PORTS],
    input  wire SqN       uopSqN[`NUM_PORTS],
    input  wire AluOp     uopOp[`NUM_PORTS],
    input  wire Word      uopImm[`NUM_PORTS],
    input  wire logic     uopImmB[`NUM_PORTS],
    input  wire FetchId   uopFetchId[`NUM_PORTS],
    input  wire FetchOffs uopFetchOffs[`NUM_PORTS],
    input  wire logic     uopCompressed[`NUM_PORTS],

    input  wire           invalidate,
    input  wire SqN       invalidateSqN,
    input  wire logic     stall[`NUM_PORTS],

    // Writeback snoop
    input  wire logic     wbValid[`NUM_PORTS],
    input  wire Tag       wbTagDst[`NUM_PORTS],
    input  wire Word      wbResult[`NUM_PORTS],

    output Tag            rfReadAddr[2*`NUM_PORTS],
    output FetchId        pcReadAddr[`NUM_PORTS],
    input  wire Word      rfReadData[2*`NUM_PORTS],
    input  wire Word      pcReadData[`NUM_PORTS],

    // Execute
    output logic          exValid[`NUM_PORTS],
    output Word           exSrcA[`NUM_PORTS],
    output Word           exSrcB[`NUM_PORTS],
    output Word           exPc[`NUM_PORTS],
    output AluOp          exOp[`NUM_PORTS],
    output Tag            exTagDst[`NUM_PORTS],
    output SqN            exSqN[`NUM_PORTS],
    output logic          exCompressed[`NUM_PORTS]
);

    // Which writeback buses are producing this tag right now
    function automatic logic [`NUM_PORTS-1:0] wbMatch(input Tag tag);
        logic [`NUM_PORTS-1:0] hits;
        for (int w = 0; w < `NUM_PORTS; w++) begin
            hits[w] = wbValid[w] && wbTagDst[w] == tag;
        end
        return hits;
    endfunction

    // Inline constant first, then forwarded result, then register file
    function automatic Word selectOperand(input Tag tag, input Word rfValue);
        Word value;
        logic [`NUM_PORTS-1:0] hits;
        hits = wbMatch(tag);
        value = rfValue;
        if (tag[`TAG_W-1]) begin
            value = {{(`WORD_W - `TAG_W + 1){tag[`TAG_W-2]}}, tag[`TAG_W-2:0]};
        end else begin
            for (int w = 0; w < `NUM_PORTS; w++) begin
                if (hits[w]) begin
                    value = wbResult[w];
                end
            end
        end
        return value;
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            rfReadAddr[i] = uopTagA[i];
            rfReadAddr[i + `NUM_PORTS] = uopTagB[i];
            pcReadAddr[i] = uopFetchId[i];
        end
    end

    // Valid bits: load when free, hold under stall unless flushed
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                exValid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (!stall[i]) begin
                    exValid[i] <= uopValid[i] &&
                        !(invalidate && isYounger(uopSqN[i], invalidateSqN));
                end else if (invalidate && isYounger(exSqN[i], invalidateSqN)) begin
                    exValid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (!stall[i] && uopValid[i]) begin
                exSrcA[i] <= selectOperand(uopTagA[i], rfReadData[i]);
                exSrcB[i] <= uopImmB[i] ? uopImm[i]
                           : selectOperand(uopTagB[i], rfReadData[i + `NUM_PORTS]);
                // Offset names the end of the instruction, so back up a full-size one
                exPc[i] <= pcReadData[i] + Word'({uopFetchOffs[i], 1'b0})
                         - (uopCompressed[i] ? 32'd0 : 32'd2);
                exOp[i] <= uopOp[i];
                exTagDst[i] <= uopTagDst[i];
                exSqN[i] <= uopSqN[i];
                exCompressed[i] <= uopCompressed[i];
            end
        end
    end

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : gFwdChk
        assert property (@(posedge clk) disable iff (rst)
            uopValid[p] |-> $onehot0(wbMatch(uopTagA[p])) && $onehot0(wbMatch(uopTagB[p])));
    end

endmodule

`default_nettype wire

/* PcFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module PcFile import CoreTypes::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         writeEn,
    input  wire FetchId writeId,
    input  wire Word    writeBase,
    input  wire FetchId readId[`NUM_PORTS],
    output Word         readBase[`NUM_PORTS]
);

    Word bases[`NUM_FETCH];

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            readBase[i] = bases[readId[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int f = 0; f < `NUM_FETCH; f++) begin
                bases[f] <= '0;
            end
        end else if (writeEn) begin
            bases[writeId] <= writeBase;
        end
    end

    // PC rebuild in the operand stage relies on 16-byte aligned blocks
    assert property (@(posedge clk) disable iff (rst)
        writeEn |-> writeBase[3:0] == 4'b0);

endmodule

`default_nettype wire

/* RegFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module RegFile import CoreTypes::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire Tag   readAddr[2*`NUM_PORTS],
    output Word       readData[2*`NUM_PORTS],
    input  wire logic writeEn[`NUM_PORTS],
    input  wire Tag   writeTag[`NUM_PORTS],
    input  wire Word  writeData[`NUM_PORTS]
);

    Word regs[`NUM_PREGS];

    // Reads see the value from before a same-cycle write
    always_comb begin
        for (int i = 0; i < 2 * `NUM_PORTS; i++) begin
            readData[i] = regs[readAddr[i][`TAG_W-2:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_PREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                // Constant tags carry no register result
                if (writeEn[i] && !writeTag[i][`TAG_W-1]) begin
                    regs[writeTag[i][`TAG_W-2:0]] <= writeData[i];
                end
            end
        end
    end

    // Rename never hands one tag to two ALUs finishing together
    for (genvar a = 0; a < `NUM_PORTS; a++) begin : gWrA
        for (genvar b = a + 1; b < `NUM_PORTS; b++) begin : gWrB
            assert property (@(posedge clk) disable iff (rst)
                !(writeEn[a] && writeEn[b] && writeTag[a] == writeTag[b]));
        end
    end

endmodule

`default_nettype wire

/* CoreTypes.sv */
`default_nettype none

`include "core_defs.svh"

package CoreTypes;

    typedef logic [`TAG_W-1:0] Tag;
    typedef logic [`SQN_W-1:0] SqN;
    typedef logic [`WORD_W-1:0] Word;
    typedef logic [$clog2(`NUM_FETCH)-1:0] FetchId;
    typedef logic [`FETCH_OFFS_W-1:0] FetchOffs;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opSll,
        opSrl,
        opLink
    } AluOp;

    typedef enum logic {
        aluIdle,
        aluShift
    } AluState;

    // Sequence numbers wrap, so age comes from the signed difference
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

/* core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Issue and execute ports, one ALU each
`define NUM_PORTS 2

// Top tag bit flags an inline constant in the low bits
`define TAG_W 7

`define SQN_W 7

`define WORD_W 32

// Physical integer registers
`define NUM_PREGS 64

// Fetch blocks tracked in the PC file
`define NUM_FETCH 8

// Halfword offset inside an 8-halfword fetch block
`define FETCH_OFFS_W 3

`endif
